//--- hw/p_predictor.sv
/*
   jump prediction package
   address, offset and JTB field constants, sweeper state encoding
*/
`default_nettype none

package p_predictor;

   // field widths shared by all JTB blocks
   localparam int FETCH_W  = 31;                   // halfword address bits 31:1
   localparam int BYTE_W   = 32;                   // full byte address
   localparam int OFFSET_W = 20;                   // jump offset in halfwords
   localparam int FLAG_W   = 1;                    // unaligned RVC flag

   // entry layout is {base, ualigc, offset}
   localparam int UALIGC_BIT = OFFSET_W;           // flag sits just above offset
   localparam int BASE_LSB   = OFFSET_W + FLAG_W;  // first base bit in entry

   // halfword fetch address, byte bits 31:1
   typedef logic [FETCH_W-1:0] fetch_add_t;

   // byte address of a jump or a predicted target
   typedef logic [BYTE_W-1:0] byte_add_t;

   // signed halfword distance from jump to target
   typedef logic signed [OFFSET_W-1:0] jump_offset_t;

   // flush sweeper states
   typedef enum logic [0:0] {
      IDLE  = 1'b0,                                // waiting for flush
      SWEEP = 1'b1                                 // walking all indices
   } sweep_state_t;

endpackage

`default_nettype wire

//--- hw/jtb_store.sv
/*
   jump target buffer storage
   entry register file with one write and one read port, valid bits
*/
`default_nettype none

module jtb_store #(
   parameter int ENTRIES = 8,                      // number of JTB entries
   parameter int ENTRY_W = 45,                     // bits per stored entry
   localparam int IDX_W  = $clog2(ENTRIES)         // index width
) (
   input  logic               s_clk_i,             // clock
   input  logic               s_resetn_i,          // sync reset, active low
   input  logic               s_we_i,              // write entry, set valid
   input  logic               s_inv_i,             // clear valid of write index
   input  logic [IDX_W-1:0]   s_wadd_i,            // write index
   input  logic [ENTRY_W-1:0] s_wdata_i,           // formatted entry
   input  logic [IDX_W-1:0]   s_radd_i,            // read index from fetch
   output logic [ENTRY_W-1:0] s_rdata_o,           // entry at read index
   output logic               s_rvalid_o           // valid bit at read index
);

   typedef logic [ENTRY_W-1:0] entry_t;
   typedef logic [ENTRIES-1:0] valid_vec_t;

   entry_t     s_entries [ENTRIES];                // jump payloads
   valid_vec_t s_valid;                            // one bit per entry
   valid_vec_t s_sel;                              // one-hot write select
   logic       s_wr_entry;                         // payload write enable

   assign s_sel      = valid_vec_t'(1) << s_wadd_i;
   assign s_wr_entry = s_we_i & ~s_inv_i;          // invalidate wins over write

   // valid vector
   always_ff @(posedge s_clk_i) begin
      if (~s_resetn_i) begin
         s_valid <= '0;                            // forget every jump
      end else if (s_inv_i) begin
         s_valid <= s_valid & ~s_sel;              // drop one entry
      end else if (s_we_i) begin
         s_valid <= s_valid | s_sel;               // new entry is live
      end
   end

   // entry payload
   always_ff @(posedge s_clk_i) begin
      if (s_wr_entry) begin
         s_entries[s_wadd_i] <= s_wdata_i;
      end
   end

   // prediction reads the entry in the same cycle
   assign s_rdata_o  = s_entries[s_radd_i];
   assign s_rvalid_o = s_valid[s_radd_i];

endmodule

`default_nettype wire

//--- hw/jump_predictor.sv
/*
   jump predictor lookup and update formatting
   read index, tag compare, unaligned check, target adder,
   write index and entry packing for the JTB
*/
`default_nettype none

module jump_predictor #(
   parameter int ENTRIES = 8,                      // number of JTB entries
   parameter int SHARED  = 8,                      // high bits not kept in tag
   localparam int IDX_W   = $clog2(ENTRIES),
   localparam int BASE_W  = 32 - IDX_W - 2 - SHARED,
   localparam int ENTRY_W = p_predictor::FLAG_W + p_predictor::OFFSET_W + BASE_W
) (
   input  p_predictor::fetch_add_t   s_fetch_add_i,   // current fetch address
   input  logic [ENTRY_W-1:0]        s_rdata_i,       // entry read from JTB
   input  logic                      s_rvalid_i,      // entry valid
   input  p_predictor::byte_add_t    s_jump_add_i,    // executed jump address
   input  p_predictor::jump_offset_t s_jump_offset_i, // executed jump offset
   input  logic                      s_ualigc_i,      // executed jump is unaligned RVC
   output logic [IDX_W-1:0]          s_radd_o,        // JTB read index
   output logic [ENTRY_W-1:0]        s_wdata_o,       // entry to store
   output logic [IDX_W-1:0]          s_wadd_o,        // JTB write index
   output logic                      s_pred_jump_o,   // jump predicted
   output p_predictor::byte_add_t    s_pred_add_o,    // predicted target
   output logic                      s_ualigc_o       // predicted jump is unaligned RVC
);

   localparam int OFF_W = p_predictor::OFFSET_W;
   localparam int SUM_W = p_predictor::FETCH_W;    // halfword target width

   typedef logic [BASE_W-1:0] base_t;
   typedef logic [SUM_W-1:0]  half_add_t;

   base_t                     s_base_p;            // stored tag
   base_t                     s_base_f;            // tag of fetch address
   base_t                     s_base_u;            // tag of updating jump
   logic                      s_ualigc_p;          // stored unaligned flag
   p_predictor::jump_offset_t s_offset_p;          // stored offset
   logic                      s_tag_hit;
   logic                      s_align_ok;
   half_add_t                 s_tbase;             // adder base operand
   half_add_t                 s_toff;              // sign-extended offset
   half_add_t                 s_tadd;              // halfword target

   // lookup side
   assign s_radd_o   = s_fetch_add_i[IDX_W:1];     // skips the halfword bit
   assign s_offset_p = s_rdata_i[OFF_W-1:0];
   assign s_ualigc_p = s_rdata_i[p_predictor::UALIGC_BIT];
   assign s_base_p   = s_rdata_i[ENTRY_W-1:p_predictor::BASE_LSB];
   assign s_base_f   = s_fetch_add_i[30-SHARED:IDX_W+1];

   assign s_tag_hit  = (s_base_p == s_base_f);
   // aligned fetch, or the upper half of an unaligned RVC jump
   assign s_align_ok = ~s_fetch_add_i[0] | s_ualigc_p;

   assign s_pred_jump_o = s_rvalid_i & s_tag_hit & s_align_ok;
   assign s_ualigc_o    = s_ualigc_p;

   // target = ({fetch[30:1], ualigc} + sext(offset)) << 1
   assign s_tbase = {s_fetch_add_i[30:1], s_ualigc_p};
   assign s_toff  = {{(SUM_W-OFF_W){s_offset_p[OFF_W-1]}}, s_offset_p};
   assign s_tadd  = s_tbase + s_toff;            // wraps like the PC

   assign s_pred_add_o = {s_tadd, 1'b0};           // back to byte address

   // update side
   assign s_wadd_o  = s_jump_add_i[IDX_W+1:2];     // word-aligned index
   assign s_base_u  = s_jump_add_i[31-SHARED:IDX_W+2];
   assign s_wdata_o = {s_base_u, s_ualigc_i, s_jump_offset_i};

endmodule

`default_nettype wire

//--- hw/jtb_flush_sweeper.sv
/*
   flush sweeper for the JTB
   walks every index from zero and requests an invalidate for each
*/
`default_nettype none

module jtb_flush_sweeper #(
   parameter int ENTRIES = 8,                      // number of JTB entries
   localparam int IDX_W  = $clog2(ENTRIES)
) (
   input  logic             s_clk_i,               // clock
   input  logic             s_resetn_i,            // sync reset, active low
   input  logic             s_flush_i,             // flush strobe, e.g. fence.i
   input  logic             s_gnt_i,               // write port granted
   output logic             s_req_o,               // invalidate request
   output logic [IDX_W-1:0] s_idx_o,               // index to invalidate
   output logic             s_busy_o               // sweep in progress
);

   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ENTRIES - 1);

   p_predictor::sweep_state_t s_state;
   p_predictor::sweep_state_t s_state_n;
   logic [IDX_W-1:0]          s_cnt;               // current sweep index
   logic                      s_last;              // last index granted

   assign s_last = s_gnt_i & (s_cnt == LAST_IDX);

   always_comb begin
      s_state_n = s_state;
      case (s_state)
         p_predictor::IDLE:  if (s_flush_i) s_state_n = p_predictor::SWEEP;
         p_predictor::SWEEP: if (s_last) s_state_n = p_predictor::IDLE;
         default:            s_state_n = p_predictor::IDLE;
      endcase
   end

   always_ff @(posedge s_clk_i) begin
      if (~s_resetn_i) begin
         s_state <= p_predictor::IDLE;
         s_cnt   <= '0;
      end else begin
         s_state <= s_state_n;
         if (s_state == p_predictor::IDLE) begin
            s_cnt <= '0;                           // every sweep starts at 0
         end else if (s_gnt_i) begin
            s_cnt <= s_cnt + 1'b1;                 // stall while exe owns port
         end
      end
   end

   assign s_busy_o = (s_state == p_predictor::SWEEP);
   assign s_req_o  = s_busy_o;
   assign s_idx_o  = s_cnt;

endmodule

`default_nettype wire

//--- hw/jtb_write_arbiter.sv
/*
   JTB write port arbiter
   execute stage has fixed priority, sweeper gets idle cycles
*/
`default_nettype none

module jtb_write_arbiter #(
   parameter int ENTRIES = 8,                      // number of JTB entries
   parameter int ENTRY_W = 45,                     // bits per stored entry
   localparam int IDX_W  = $clog2(ENTRIES)
) (
   input  logic               s_jump_update_i,     // exe writes an entry
   input  logic               s_invalidate_i,      // exe clears an entry
   input  logic [IDX_W-1:0]   s_exe_idx_i,         // exe index
   input  logic [ENTRY_W-1:0] s_exe_wdata_i,       // exe formatted entry
   input  logic               s_sweep_req_i,       // sweeper wants the port
   input  logic [IDX_W-1:0]   s_sweep_idx_i,       // sweeper index
   output logic               s_sweep_gnt_o,       // sweeper owns port this cycle
   output logic               s_we_o,              // store write enable
   output logic               s_inv_o,             // store invalidate enable
   output logic [IDX_W-1:0]   s_wadd_o,            // store write index
   output logic [ENTRY_W-1:0] s_wdata_o            // store write data
);

   logic s_exe_act;                                // any exe strobe

   assign s_exe_act     = s_jump_update_i | s_invalidate_i;
   assign s_sweep_gnt_o = s_sweep_req_i & ~s_exe_act;

   // command mux, sweeper can only invalidate
   always_comb begin
      if (s_exe_act) begin
         s_we_o   = s_jump_update_i & ~s_invalidate_i; // invalidate wins
         s_inv_o  = s_invalidate_i;
         s_wadd_o = s_exe_idx_i;
      end else begin
         s_we_o   = 1'b0;
         s_inv_o  = s_sweep_gnt_o;
         s_wadd_o = s_sweep_idx_i;
      end
   end

   assign s_wdata_o = s_exe_wdata_i;               // only exe ever writes payload

endmodule

`default_nettype wire

//--- hw/fetch_predict_top.sv
/*
   fetch stage jump prediction top
   predictor, JTB store, flush sweeper and write arbiter
*/
`default_nettype none

module fetch_predict_top #(
   parameter int ENTRIES = 8,                      // JTB entries, power of two
   parameter int SHARED  = 8                       // high bits shared with fetch
) (
   input  logic                      s_clk_i,         // clock
   input  logic                      s_resetn_i,      // sync reset, active low
   input  p_predictor::fetch_add_t   s_fetch_add_i,   // fetch address
   input  logic                      s_jump_update_i, // exe update strobe
   input  logic                      s_invalidate_i,  // exe invalidate strobe
   input  logic                      s_ualigc_i,      // exe jump is unaligned RVC
   input  p_predictor::jump_offset_t s_jump_offset_i, // exe jump offset
   input  p_predictor::byte_add_t    s_jump_add_i,    // exe jump address
   input  logic                      s_flush_i,       // flush strobe
   output logic                      s_pred_jump_o,   // jump predicted
   output p_predictor::byte_add_t    s_pred_add_o,    // predicted target
   output logic                      s_ualigc_o,      // predicted unaligned RVC
   output logic                      s_flush_busy_o   // sweep running
);

   localparam int IDX_W   = $clog2(ENTRIES);
   localparam int BASE_W  = 32 - IDX_W - 2 - SHARED;
   localparam int ENTRY_W = p_predictor::FLAG_W + p_predictor::OFFSET_W + BASE_W;

   logic [IDX_W-1:0]   s_radd;                     // lookup index
   logic [ENTRY_W-1:0] s_rdata;                    // looked-up entry
   logic               s_rvalid;
   logic [IDX_W-1:0]   s_exe_idx;                  // update index from exe
   logic [ENTRY_W-1:0] s_exe_wdata;                // packed update entry
   logic               s_sweep_req;
   logic [IDX_W-1:0]   s_sweep_idx;
   logic               s_sweep_gnt;
   logic               s_we;                       // arbitrated port
   logic               s_inv;
   logic [IDX_W-1:0]   s_wadd;
   logic [ENTRY_W-1:0] s_wdata;

   jump_predictor #(.ENTRIES(ENTRIES), .SHARED(SHARED)) jump_predictor_i (
      .s_fetch_add_i  (s_fetch_add_i),
      .s_rdata_i      (s_rdata),
      .s_rvalid_i     (s_rvalid),
      .s_jump_add_i   (s_jump_add_i),
      .s_jump_offset_i(s_jump_offset_i),
      .s_ualigc_i     (s_ualigc_i),
      .s_radd_o       (s_radd),
      .s_wdata_o      (s_exe_wdata),
      .s_wadd_o       (s_exe_idx),
      .s_pred_jump_o  (s_pred_jump_o),
      .s_pred_add_o   (s_pred_add_o),
      .s_ualigc_o     (s_ualigc_o)
   );

   jtb_flush_sweeper #(.ENTRIES(ENTRIES)) jtb_flush_sweeper_i (
      .s_clk_i   (s_clk_i),
      .s_resetn_i(s_resetn_i),
      .s_flush_i (s_flush_i),
      .s_gnt_i   (s_sweep_gnt),
      .s_req_o   (s_sweep_req),
      .s_idx_o   (s_sweep_idx),
      .s_busy_o  (s_flush_busy_o)
   );

   jtb_write_arbiter #(.ENTRIES(ENTRIES), .ENTRY_W(ENTRY_W)) jtb_write_arbiter_i (
      .s_jump_update_i(s_jump_update_i),
      .s_invalidate_i (s_invalidate_i),
      .s_exe_idx_i    (s_exe_idx),
      .s_exe_wdata_i  (s_exe_wdata),
      .s_sweep_req_i  (s_sweep_req),
      .s_sweep_idx_i  (s_sweep_idx),
      .s_sweep_gnt_o  (s_sweep_gnt),
      .s_we_o         (s_we),
      .s_inv_o        (s_inv),
      .s_wadd_o       (s_wadd),
      .s_wdata_o      (s_wdata)
   );

   jtb_store #(.ENTRIES(ENTRIES), .ENTRY_W(ENTRY_W)) jtb_store_i (
      .s_clk_i   (s_clk_i),
      .s_resetn_i(s_resetn_i),
      .s_we_i    (s_we),
      .s_inv_i   (s_inv),
      .s_wadd_i  (s_wadd),
      .s_wdata_i (s_wdata),
      .s_radd_i  (s_radd),
      .s_rdata_o (s_rdata),
      .s_rvalid_o(s_rvalid)
   );

endmodule

`default_nettype wire

//--- verification/fetch_predict_props.sv
/*
   concurrent checks on JTB write arbitration and the flush sweep
*/
`default_nettype none

module fetch_predict_props #(
   parameter int ENTRIES = 8                       // number of JTB entries
) (
   input logic s_clk_i,
   input logic s_resetn_i,
   input logic s_flush_i,                          // flush strobe
   input logic s_exe_act_i,                        // any exe strobe
   input logic s_sweep_gnt_i,                      // sweeper owns the port
   input logic s_busy_i                            // sweep running
);
   timeunit 1ns;
   timeprecision 100ps;

   int s_busy_cycles;                              // cycles spent in this sweep
   int s_stalls;                                   // cycles lost to exe strobes

   always_ff @(posedge s_clk_i) begin
      if (~s_resetn_i | ~s_busy_i) begin
         s_busy_cycles <= 0;
         s_stalls      <= 0;
      end else begin
         s_busy_cycles <= s_busy_cycles + 1;
         s_stalls      <= s_stalls + (s_sweep_gnt_i ? 0 : 1);
      end
   end

   a_gnt_excl: assert property (@(posedge s_clk_i) disable iff (~s_resetn_i)
      s_sweep_gnt_i |-> ~s_exe_act_i) else $error("sweeper granted during exe strobe");

   a_busy_bound: assert property (@(posedge s_clk_i) disable iff (~s_resetn_i)
      s_busy_i |-> (s_busy_cycles < ENTRIES + s_stalls)) else $error("sweep overran");

   a_reset_idle: assert property (@(posedge s_clk_i)
      ~s_resetn_i |=> ~s_busy_i) else $error("busy high after reset");

   a_busy_start: assert property (@(posedge s_clk_i) disable iff (~s_resetn_i)
      $rose(s_busy_i) |-> $past(s_flush_i)) else $error("sweep started without flush");

endmodule

// attached at the top, where arbiter grant and sweeper busy meet
bind fetch_predict_top fetch_predict_props #(.ENTRIES(ENTRIES)) fetch_predict_props_i (
   .s_clk_i      (s_clk_i),
   .s_resetn_i   (s_resetn_i),
   .s_flush_i    (s_flush_i),
   .s_exe_act_i  (s_jump_update_i | s_invalidate_i),
   .s_sweep_gnt_i(s_sweep_gnt),
   .s_busy_i     (s_flush_busy_o)
);

`default_nettype wire

//--- verification/tb_fetch_predict.sv
/*
   testbench for the fetch stage jump predictor
   shadow JTB model, reference lookup, per-cycle compare,
   directed hit, unaligned, invalidate and flush tests, random traffic
*/
`default_nettype none

module tb_fetch_predict;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ENTRIES   = 8;
   localparam int SHARED    = 8;
   localparam int IDX_W     = $clog2(ENTRIES);
   localparam int BASE_W    = 32 - IDX_W - 2 - SHARED;
   localparam int FLUSH_TMO = 200;                 // cycles allowed for one sweep

   typedef logic [BASE_W-1:0] tag_t;

   logic                      s_clk;
   logic                      s_resetn;
   p_predictor::fetch_add_t   s_fetch_add;
   logic                      s_jump_update;
   logic                      s_invalidate;
   logic                      s_ualigc;
   p_predictor::jump_offset_t s_jump_offset;
   p_predictor::byte_add_t    s_jump_add;
   logic                      s_flush;
   logic                      s_pred_jump;
   p_predictor::byte_add_t    s_pred_add;
   logic                      s_pred_ualigc;
   logic                      s_flush_busy;

   // shadow JTB
   logic                      m_valid [ENTRIES];
   tag_t                      m_tag [ENTRIES];
   p_predictor::jump_offset_t m_off [ENTRIES];
   logic                      m_ual [ENTRIES];
   logic                      m_kept [ENTRIES];    // written behind the sweep
   logic                      m_busy;
   int                        m_sweep_idx;         // next index to clear

   logic check_en;                                 // compare once model is reset
   int   n_checks;
   int   seed;

   fetch_predict_top #(.ENTRIES(ENTRIES), .SHARED(SHARED)) fetch_predict_top_i (
      .s_clk_i        (s_clk),
      .s_resetn_i     (s_resetn),
      .s_fetch_add_i  (s_fetch_add),
      .s_jump_update_i(s_jump_update),
      .s_invalidate_i (s_invalidate),
      .s_ualigc_i     (s_ualigc),
      .s_jump_offset_i(s_jump_offset),
      .s_jump_add_i   (s_jump_add),
      .s_flush_i      (s_flush),
      .s_pred_jump_o  (s_pred_jump),
      .s_pred_add_o   (s_pred_add),
      .s_ualigc_o     (s_pred_ualigc),
      .s_flush_busy_o (s_flush_busy)
   );

   initial begin
      s_clk = 1'b0;
      forever begin
         #2 s_clk = ~s_clk;                        // 4 ns period
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         abort_run($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_target(input string name, input p_predictor::byte_add_t got,
                               input p_predictor::byte_add_t exp);
      n_checks++;
      if (got !== exp) begin
         abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   // expected lookup, worked out on byte addresses
   function automatic logic ref_predict(input p_predictor::fetch_add_t fa,
                                        output p_predictor::byte_add_t tgt, output logic ual);
      p_predictor::byte_add_t ba;
      p_predictor::byte_add_t step;
      int                     idx;
      ba   = {fa, 1'b0};
      idx  = int'(ba[IDX_W+1:2]);
      step = {{11{m_off[idx][19]}}, m_off[idx], 1'b0};  // halfwords to bytes
      tgt  = {ba[31:2], m_ual[idx], 1'b0} + step;
      ual  = m_ual[idx];
      ref_predict = m_valid[idx] && (m_tag[idx] == ba[31-SHARED:IDX_W+2]) &&
                    (!fa[0] || m_ual[idx]);
   endfunction

   always @(posedge s_clk) begin : model
      int idx;
      idx = int'(s_jump_add[IDX_W+1:2]);
      if (!s_resetn) begin
         for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_kept[i]  = 1'b0;
         end
         m_busy      = 1'b0;
         m_sweep_idx = 0;
      end else begin
         if (s_invalidate) begin
            m_valid[idx] = 1'b0;                   // beats a same-cycle update
            m_kept[idx]  = 1'b0;
         end else if (s_jump_update) begin
            m_valid[idx] = 1'b1;
            m_tag[idx]   = s_jump_add[31-SHARED:IDX_W+2];
            m_off[idx]   = s_jump_offset;
            m_ual[idx]   = s_ualigc;
            m_kept[idx]  = m_busy && (idx < m_sweep_idx);
         end
         if (m_busy && !(s_jump_update || s_invalidate)) begin
            m_valid[m_sweep_idx] = 1'b0;           // free cycle, sweep moves on
            m_busy      = (m_sweep_idx != ENTRIES - 1);
            m_sweep_idx = m_sweep_idx + 1;
         end else if (!m_busy && s_flush) begin
            m_busy      = 1'b1;
            m_sweep_idx = 0;
            for (int i = 0; i < ENTRIES; i++) begin
               m_kept[i] = 1'b0;
            end
         end
      end
   end

   always @(negedge s_clk) begin : compare
      p_predictor::byte_add_t exp_add;
      logic                   exp_ual;
      logic                   exp_jump;
      if (check_en) begin
         exp_jump = ref_predict(s_fetch_add, exp_add, exp_ual);
         check_flag("s_pred_jump_o", s_pred_jump, exp_jump);
         check_flag("s_flush_busy_o", s_flush_busy, m_busy);
         if (exp_jump) begin
            check_target("s_pred_add_o", s_pred_add, exp_add);
            check_flag("s_ualigc_o", s_pred_ualigc, exp_ual);
         end
      end
   end

   task automatic next_cycle();
      @(posedge s_clk);
      #1;                                          // drive point
   endtask

   function automatic p_predictor::byte_add_t make_add(input tag_t tag, input int idx,
                                                       input logic [SHARED-1:0] hi);
      make_add = {hi, tag, idx[IDX_W-1:0], 2'b00};
   endfunction

   task automatic send_update(input p_predictor::byte_add_t add,
                              input p_predictor::jump_offset_t off, input logic ual,
                              input logic inv);
      s_jump_add    = add;
      s_jump_offset = off;
      s_ualigc      = ual;
      s_jump_update = 1'b1;
      s_invalidate  = inv;                         // both strobes on request
      next_cycle();
      s_jump_update = 1'b0;
      s_invalidate  = 1'b0;
   endtask

   task automatic send_invalidate(input p_predictor::byte_add_t add);
      s_jump_add   = add;
      s_invalidate = 1'b1;
      next_cycle();
      s_invalidate = 1'b0;
   endtask

   task automatic fetch_expect(input p_predictor::byte_add_t add, input logic odd,
                               input logic exp);
      s_fetch_add = {add[31:2], odd};
      @(negedge s_clk);
      check_flag("s_pred_jump_o", s_pred_jump, exp);
      next_cycle();
   endtask

   task automatic target_expect(input p_predictor::byte_add_t add,
                                input p_predictor::byte_add_t exp);
      s_fetch_add = {add[31:2], 1'b0};
      @(negedge s_clk);
      check_target("s_pred_add_o", s_pred_add, exp);
      next_cycle();
   endtask

   initial begin
      int                        r;
      int                        n;
      p_predictor::byte_add_t    add;
      p_predictor::jump_offset_t off;
      tag_t                      tag_a;
      seed          = 32'h85e;
      check_en      = 1'b0;
      n_checks      = 0;
      s_resetn      = 1'b0;
      s_fetch_add   = '0;
      s_jump_update = 1'b0;
      s_invalidate  = 1'b0;
      s_ualigc      = 1'b0;
      s_jump_offset = '0;
      s_jump_add    = '0;
      s_flush       = 1'b0;
      next_cycle();
      check_en = 1'b1;                             // model reset at first edge
      repeat (3) next_cycle();
      s_resetn = 1'b1;

      // empty JTB
      for (int k = 0; k < 16; k++) begin
         r = $random(seed);
         fetch_expect(p_predictor::byte_add_t'(r), r[0], 1'b0);
      end

      // hits, aliasing and target sign
      tag_a = tag_t'($random(seed));
      add   = make_add(tag_a, 3, 8'h12);
      send_update(add, 20'sh00123, 1'b0, 1'b0);
      fetch_expect(add, 1'b0, 1'b1);
      fetch_expect(make_add(tag_a, 3, 8'ha5), 1'b0, 1'b1);  // top bits not in tag
      fetch_expect(make_add(tag_a ^ tag_t'(1), 3, 8'h12), 1'b0, 1'b0);
      target_expect(add, add + 32'h246);
      add = make_add(tag_a, 5, 8'h00);
      send_update(add, -20'sd40, 1'b0, 1'b0);      // backward jump
      target_expect(add, add - 32'd80);

      // unaligned RVC
      add = make_add(tag_a, 2, 8'h00);
      send_update(add, 20'sh00010, 1'b0, 1'b0);
      fetch_expect(add, 1'b1, 1'b0);
      add = make_add(tag_a, 6, 8'h00);
      send_update(add, 20'sh00010, 1'b1, 1'b0);
      fetch_expect(add, 1'b1, 1'b1);
      fetch_expect(add, 1'b0, 1'b1);

      // single invalidate, then both strobes together
      for (int i = 0; i < ENTRIES; i++) begin
         send_update(make_add(tag_a, i, 8'h00), p_predictor::jump_offset_t'(i * 3 - 10),
                     i[0], 1'b0);
      end
      send_invalidate(make_add(tag_a, 4, 8'h00));
      for (int i = 0; i < ENTRIES; i++) begin
         fetch_expect(make_add(tag_a, i, 8'h00), 1'b0, i != 4);
      end
      add = make_add(tag_a, 1, 8'h00);
      send_update(add, 20'sh00055, 1'b1, 1'b1);
      fetch_expect(add, 1'b0, 1'b0);

      // flush without contention lasts ENTRIES cycles
      s_flush = 1'b1;
      next_cycle();
      s_flush = 1'b0;
      n = 0;
      while (s_flush_busy) begin
         next_cycle();
         n++;
         if (n > FLUSH_TMO) begin
            abort_run("flush busy did not fall after an idle flush");
         end
      end
      if (n != ENTRIES) begin
         abort_run($sformatf("idle flush took %0d cycles instead of %0d", n, ENTRIES));
      end

      // flush with updates interleaved and a second flush ignored
      for (int i = 0; i < ENTRIES; i++) begin
         send_update(make_add(tag_a, i, 8'h00), 20'sh00200, 1'b0, 1'b0);
      end
      s_flush = 1'b1;
      next_cycle();
      n = 0;
      while (s_flush_busy) begin
         r       = $random(seed);
         s_flush = (n == 3);
         if (r[1:0] == 2'b00) begin
            send_update(make_add(tag_a, r[4:2], 8'h00), p_predictor::jump_offset_t'(r[31:12]),
                        r[5], 1'b0);
         end else begin
            next_cycle();
         end
         n++;
         if (n > FLUSH_TMO) begin
            abort_run("flush busy did not fall during a flush with updates");
         end
      end
      s_flush = 1'b0;
      for (int i = 0; i < ENTRIES; i++) begin
         fetch_expect(make_add(m_tag[i], i, 8'h00), 1'b0, m_kept[i]);
      end

      // random mix
      for (int k = 0; k < 400; k++) begin
         r   = $random(seed);
         off = p_predictor::jump_offset_t'($random(seed));
         add = make_add(tag_a ^ tag_t'(r[8]), r[11:9], r[19:12]);  // two tags alias
         s_fetch_add = {add[31:2], r[20]};
         case (r[23:21])
            3'd0, 3'd1: send_update(add, off, r[24], 1'b0);
            3'd2:       send_update(add, off, r[24], 1'b1);
            3'd3:       send_invalidate(add);
            3'd4: begin
               s_flush = r[25] & r[26];
               next_cycle();
               s_flush = 1'b0;
            end
            default:    next_cycle();
         endcase
      end
      next_cycle();

      if (n_checks > 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         abort_run("no DUT output was compared");
      end
   end

endmodule

`default_nettype wire

//--- flist.f
hw/p_predictor.sv
hw/jtb_store.sv
hw/jump_predictor.sv
hw/jtb_flush_sweeper.sv
hw/jtb_write_arbiter.sv
hw/fetch_predict_top.sv
verification/fetch_predict_props.sv
verification/tb_fetch_predict.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the jump predictor testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module tb_fetch_predict -f flist.f -o sim_fetch_predict

./obj_dir/sim_fetch_predict | tee sim.log

if grep -q "all tests passed" sim.log; then
   echo "simulation ok"
else
   echo "simulation failed"
   exit 1
fi
